// ==== common/obj_pkg.sv ====
// object line table package with record types, builder states and window limits
package obj_pkg;

    // low attribute byte, copied as a whole into the line entry
    typedef struct packed {
        logic       b7;
        logic       vflip;
        logic       hflip;
        logic [4:0] pal;
    } obj_pal_t;

    typedef struct packed {
        logic [3:0] tile_m;   // height minus one
        logic [3:0] tile_n;   // width minus one
        obj_pal_t   pal_low;  // attribute bits 7:0
    } obj_attr_t;

    typedef struct packed {
        obj_attr_t   attr;
        logic [15:0] code;    // top nibble already bank mapped
        logic [8:0]  y;
        logic [8:0]  x;
    } obj_rec_t;

    typedef struct packed {
        logic [3:0]  zero;
        logic [3:0]  vsub;
        logic [7:0]  pal_low;
        logic [15:0] code;
        logic [15:0] xpos;
    } line_entry_t;

    typedef enum logic [3:0] {
        idle,
        fetch_attr,
        fetch_code,
        fetch_y,
        fetch_x,
        map_code,
        check_zone,
        write_info,
        write_code,
        write_x,
        next_tile,
        fill_info,
        fill_code,
        fill_x
    } obj_state_e;

    typedef enum logic [1:0] {
        word_info = 2'd0,
        word_code = 2'd1,
        word_x    = 2'd2   // word 3 of a slot stays unused
    } line_word_e;

    typedef enum logic [1:0] {
        fw_attr,
        fw_code,
        fw_y,
        fw_x
    } frame_word_e;

    localparam logic [15:0] fill_word  = 16'hffff;
    localparam logic [15:0] x_min      = 16'h0030;
    localparam logic [15:0] x_max      = 16'd448;
    localparam logic [7:0]  end_marker = 8'hff;   // attribute high byte closing the list

endpackage

// ==== logic/obj_zone_match.sv ====
// vertical zone match giving tile row and sub-line of an object on the current line
`timescale 1ns/1ps

module obj_zone_match (
    input  logic [8:0]        line_sel,
    input  obj_pkg::obj_rec_t obj,
    output logic              inzone,
    output logic [3:0]        tile_row,
    output logic [3:0]        vsub
);
    logic [8:0] diff;   // line distance below the object top, wraps at 512
    logic       vflip;

    assign diff  = line_sel - obj.y;
    assign vflip = obj.attr.pal_low.vflip;

    // covered when diff < 16*(tile_m+1)
    assign inzone = diff[8:4] <= {1'b0, obj.attr.tile_m};

    assign tile_row = vflip ? obj.attr.tile_m - diff[7:4] : diff[7:4];
    assign vsub     = diff[3:0] ^ {4{vflip}};   // upside-down inside the tile too

endmodule

// ==== logic/obj_code_expand.sv ====
// per-tile code and effective x for one line entry of a multi-tile object
`timescale 1ns/1ps

module obj_code_expand (
    input  obj_pkg::obj_rec_t     obj,
    input  logic [3:0]            tile_row,
    input  logic [3:0]            tile_col,
    input  logic [3:0]            npos,
    input  logic [3:0]            vsub,
    output obj_pkg::line_entry_t  entry,
    output logic                  visible
);
    import obj_pkg::*;

    always_comb begin
        entry.zero    = 4'd0;
        entry.vsub    = vsub;
        entry.pal_low = obj.attr.pal_low;
        // row and column each wrap inside their own nibble
        entry.code    = {obj.code[15:8], obj.code[7:4] + tile_row, obj.code[3:0] + tile_col};
        entry.xpos    = {7'd0, obj.x} + {8'd0, npos, 4'd0};
    end

    assign visible = (entry.xpos > x_min) && (entry.xpos < x_max);

endmodule

// ==== logic/gfx_bank_mapper.sv ====
// graphics bank mapper picking offset and mask nibbles by code range
`timescale 1ns/1ps

module gfx_bank_mapper (
    input  logic        clk,
    input  logic        rst,
    input  logic [1:0]  map_in,        // code bits 15:14
    input  logic [15:0] bank_offset,
    input  logic [15:0] bank_mask,
    output logic [3:0]  offset,
    output logic [3:0]  mask
);
    // builder forms (code[15:12] & mask) | offset from these
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            offset <= '0;
            mask   <= '0;
        end else begin
            offset <= bank_offset[{map_in, 2'b00} +: 4];
            mask   <= bank_mask[{map_in, 2'b00} +: 4];
        end
    end

endmodule

// ==== obj_table/obj_line_fsm.sv ====
// object line builder FSM walking the frame table and sequencing line writes
`timescale 1ns/1ps

module obj_line_fsm #(
    parameter int frame_objs = 256
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            start,
    input  logic                            flip,
    input  logic [8:0]                      vrender,
    input  logic [15:0]                     frame_data,
    input  logic [3:0]                      offset,
    input  logic [3:0]                      mask,
    input  logic                            inzone,
    input  logic                            visible,
    input  logic                            last_col,
    input  logic                            line_full,
    output logic [$clog2(frame_objs)+1:0]   frame_addr,
    output obj_pkg::obj_rec_t               obj,
    output logic [8:0]                      line_sel,
    output logic [1:0]                      map_in,
    output logic                            cnt_clear,
    output logic                            load_obj,
    output logic                            step_tile,
    output logic                            step_slot,
    output logic                            wr_en,
    output obj_pkg::line_word_e             wr_word,
    output logic                            wr_bank,
    output logic                            fill,
    output logic                            done
);
    import obj_pkg::*;

    localparam int idx_w = $clog2(frame_objs);

    obj_state_e  state;
    obj_rec_t    prev;          // record before obj, for the repeat check
    obj_attr_t   attr_q;
    logic [15:0] raw_code;      // code before bank mapping
    logic [8:0]  y_q;
    logic        first;
    logic        last_obj;
    logic        repeated;
    logic        end_list;
    logic        skip;

    assign last_obj = frame_addr[idx_w+1:2] == idx_w'(frame_objs - 1);
    assign repeated = obj == prev;
    assign end_list = {obj.attr.tile_m, obj.attr.tile_n} == end_marker;
    assign skip     = !first && (repeated || !inzone);
    assign map_in   = raw_code[15:14];
    assign wr_bank  = line_sel[0];

    always_comb begin
        cnt_clear = state == idle;
        load_obj  = state == check_zone;   // counter ready for write_info
        step_tile = 1'b0;
        step_slot = 1'b0;
        wr_en     = 1'b0;
        wr_word   = word_info;
        fill      = 1'b0;
        case (state)
            write_info: wr_en = 1'b1;
            write_code: begin
                wr_en   = 1'b1;
                wr_word = word_code;
            end
            write_x: begin
                wr_en   = 1'b1;
                wr_word = word_x;
            end
            next_tile: begin
                step_slot = visible && !line_full;    // off-window entries reuse the slot
                step_tile = !last_col && !(visible && line_full);
            end
            fill_info: begin
                wr_en = 1'b1;
                fill  = 1'b1;
            end
            fill_code: begin
                wr_en   = 1'b1;
                fill    = 1'b1;
                wr_word = word_code;
            end
            fill_x: begin
                wr_en     = 1'b1;
                fill      = 1'b1;
                wr_word   = word_x;
                step_slot = !line_full;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= idle;
            frame_addr <= '0;
            line_sel   <= '0;
            first      <= 1'b1;
            done       <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                idle: if (start) begin
                    state      <= fetch_attr;
                    frame_addr <= '0;
                    first      <= 1'b1;
                    line_sel   <= vrender ^ {1'b0, {8{flip}}};
                end
                fetch_attr: begin
                    frame_addr[1:0] <= fw_code;
                    state           <= fetch_code;
                end
                fetch_code: begin
                    frame_addr[1:0] <= fw_y;
                    state           <= fetch_y;
                end
                fetch_y: begin
                    frame_addr[1:0] <= fw_x;
                    state           <= fetch_x;
                end
                fetch_x:  state <= map_code;     // mapper result lands next cycle
                map_code: state <= check_zone;
                check_zone: begin
                    first <= 1'b0;
                    if (end_list) begin
                        state <= fill_info;
                    end else if (!skip) begin
                        state <= write_info;
                    end else if (last_obj) begin
                        state <= fill_info;
                    end else begin
                        frame_addr <= {frame_addr[idx_w+1:2] + 1'b1, fw_attr};
                        state      <= fetch_attr;
                    end
                end
                write_info: state <= write_code;
                write_code: state <= write_x;
                write_x:    state <= next_tile;
                next_tile: begin
                    if (visible && line_full) begin
                        state <= idle;          // no slot left to fill
                        done  <= 1'b1;
                    end else if (!last_col) begin
                        state <= write_info;
                    end else if (last_obj) begin
                        state <= fill_info;
                    end else begin
                        frame_addr <= {frame_addr[idx_w+1:2] + 1'b1, fw_attr};
                        state      <= fetch_attr;
                    end
                end
                fill_info: state <= fill_code;
                fill_code: state <= fill_x;
                fill_x: begin
                    if (line_full) begin
                        state <= idle;
                        done  <= 1'b1;
                    end else begin
                        state <= fill_info;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // frame words show up one state after their address
    always_ff @(posedge clk) begin
        case (state)
            fetch_code: attr_q   <= frame_data;
            fetch_y:    raw_code <= frame_data;
            fetch_x:    y_q      <= frame_data[8:0];
            map_code: begin
                prev     <= obj;
                obj.attr <= attr_q;
                obj.code <= {(raw_code[15:12] & mask) | offset, raw_code[11:0]};
                obj.y    <= y_q;
                obj.x    <= frame_data[8:0];
            end
            default: ;
        endcase
    end

    a_no_write_idle: assert property (@(posedge clk) disable iff (rst)
        state == idle |-> !wr_en);

endmodule

// ==== obj_table/obj_tile_counter.sv ====
// tile column, x tile position and line slot counter for the object builder
`timescale 1ns/1ps

module obj_tile_counter #(
    parameter int line_slots = 128
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          clear,
    input  logic                          load_obj,
    input  logic                          step_tile,
    input  logic                          step_slot,
    input  logic [3:0]                    tile_n,
    input  logic                          hflip,
    output logic [3:0]                    tile_col,
    output logic [3:0]                    npos,
    output logic [$clog2(line_slots)-1:0] slot,
    output logic                          last_col,
    output logic                          line_full
);
    localparam int slot_w = $clog2(line_slots);
    localparam logic [slot_w-1:0] slot_last = slot_w'(line_slots - 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tile_col <= '0;
            npos     <= '0;
            slot     <= '0;
        end else if (clear) begin
            tile_col <= '0;
            npos     <= '0;
            slot     <= '0;
        end else begin
            if (load_obj) begin
                tile_col <= '0;
                npos     <= hflip ? tile_n : 4'd0;   // mirrored objects start at the right
            end else if (step_tile) begin
                tile_col <= tile_col + 4'd1;
                npos     <= hflip ? npos - 4'd1 : npos + 4'd1;
            end
            if (step_slot)
                slot <= slot + 1'b1;
        end
    end

    assign last_col  = tile_col == tile_n;
    assign line_full = slot == slot_last;

endmodule

// ==== obj_table/obj_line_buf.sv ====
// double-buffered object line memory, one bank written while the other is read
`timescale 1ns/1ps

module obj_line_buf #(
    parameter int line_slots = 128
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          wr_en,
    input  logic                          wr_bank,
    input  logic [$clog2(line_slots)-1:0] wr_slot,
    input  obj_pkg::line_word_e           wr_word,
    input  obj_pkg::line_entry_t          entry,
    input  logic                          fill,
    input  logic [$clog2(line_slots)+1:0] line_addr,
    output logic [15:0]                   line_data
);
    import obj_pkg::*;

    logic [15:0] mem [0:8*line_slots-1];   // two banks of four words per slot
    logic [15:0] wr_data;

    always_comb begin
        case (wr_word)
            word_info: wr_data = {entry.zero, entry.vsub, entry.pal_low};
            word_code: wr_data = entry.code;
            default:   wr_data = entry.xpos;
        endcase
        if (fill)
            wr_data = fill_word;
    end

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[{wr_bank, wr_slot, wr_word}] <= wr_data;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            line_data <= '0;
        else
            line_data <= mem[{~wr_bank, line_addr}];   // renderer side, finished bank
    end

    a_data_reset: assert property (@(posedge clk) rst |-> line_data == '0);

endmodule

// ==== obj_table/obj_line_table_top.sv ====
// object line table builder top with FSM, counter, matcher, expander, mapper and buffer
`timescale 1ns/1ps

module obj_line_table_top #(
    parameter int line_slots = 128,
    parameter int frame_objs = 256
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  logic                          flip,
    input  logic [8:0]                    vrender,
    input  logic [15:0]                   bank_offset,
    input  logic [15:0]                   bank_mask,
    output logic [$clog2(frame_objs)+1:0] frame_addr,
    input  logic [15:0]                   frame_data,
    input  logic [$clog2(line_slots)+1:0] line_addr,
    output logic [15:0]                   line_data,
    output logic                          done
);
    import obj_pkg::*;

    obj_rec_t    obj;
    line_entry_t entry;
    line_word_e  wr_word;
    logic [8:0]  line_sel;
    logic [1:0]  map_in;
    logic [3:0]  offset, mask;
    logic        inzone, visible;
    logic [3:0]  tile_row, vsub, tile_col, npos;
    logic [$clog2(line_slots)-1:0] slot;
    logic        last_col, line_full;
    logic        cnt_clear, load_obj, step_tile, step_slot;
    logic        wr_en, wr_bank, fill;

    obj_line_fsm #(.frame_objs(frame_objs)) obj_line_fsm_i (
        .clk(clk), .rst(rst), .start(start), .flip(flip), .vrender(vrender),
        .frame_data(frame_data), .offset(offset), .mask(mask),
        .inzone(inzone), .visible(visible), .last_col(last_col), .line_full(line_full),
        .frame_addr(frame_addr), .obj(obj), .line_sel(line_sel), .map_in(map_in),
        .cnt_clear(cnt_clear), .load_obj(load_obj), .step_tile(step_tile),
        .step_slot(step_slot), .wr_en(wr_en), .wr_word(wr_word), .wr_bank(wr_bank),
        .fill(fill), .done(done)
    );

    obj_tile_counter #(.line_slots(line_slots)) obj_tile_counter_i (
        .clk(clk), .rst(rst), .clear(cnt_clear), .load_obj(load_obj),
        .step_tile(step_tile), .step_slot(step_slot),
        .tile_n(obj.attr.tile_n), .hflip(obj.attr.pal_low.hflip),
        .tile_col(tile_col), .npos(npos), .slot(slot),
        .last_col(last_col), .line_full(line_full)
    );

    obj_zone_match obj_zone_match_i (
        .line_sel(line_sel), .obj(obj),
        .inzone(inzone), .tile_row(tile_row), .vsub(vsub)
    );

    obj_code_expand obj_code_expand_i (
        .obj(obj), .tile_row(tile_row), .tile_col(tile_col), .npos(npos), .vsub(vsub),
        .entry(entry), .visible(visible)
    );

    gfx_bank_mapper gfx_bank_mapper_i (
        .clk(clk), .rst(rst), .map_in(map_in),
        .bank_offset(bank_offset), .bank_mask(bank_mask),
        .offset(offset), .mask(mask)
    );

    obj_line_buf #(.line_slots(line_slots)) obj_line_buf_i (
        .clk(clk), .rst(rst), .wr_en(wr_en), .wr_bank(wr_bank), .wr_slot(slot),
        .wr_word(wr_word), .entry(entry), .fill(fill),
        .line_addr(line_addr), .line_data(line_data)
    );

endmodule

// ==== sim/obj_checker.sv ====
// line buffer read checker with per-test results and closing counts
`timescale 1ns/1ps

module obj_checker (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] line_data,
    input  logic        sample,     // line_data holds a read result
    input  logic        exact,
    input  logic [1:0]  word_idx,
    input  logic [15:0] exp_data,
    input  logic        test_end,
    input  logic [15:0] test_id,
    input  logic [15:0] exp_used,
    input  logic        summary,
    output int          err_count
);
    int used;        // slots whose info word is not fill
    int test_errs;
    int n_tests;
    int n_failed;

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            used      = 0;
            test_errs = 0;
            n_tests   = 0;
            n_failed  = 0;
            err_count = 0;
        end else begin
            if (sample) begin
                if (word_idx == 2'd0 && line_data != 16'hffff)
                    used++;
                if (exact && line_data !== exp_data) begin
                    $display("Mismatch at %0t: word %0d read %h, expected %h",
                             $time, word_idx, line_data, exp_data);
                    test_errs++;
                    err_count++;
                end
            end
            if (test_end) begin
                if (used != int'(exp_used)) begin
                    $display("Mismatch at %0t: test %0d holds %0d entries, expected %0d",
                             $time, test_id, used, exp_used);
                    test_errs++;
                    err_count++;
                end
                if (test_errs == 0)
                    $display("test %0d passed", test_id);
                else
                    $display("test %0d failed with %0d errors", test_id, test_errs);
                n_tests++;
                if (test_errs != 0)
                    n_failed++;
                used      = 0;
                test_errs = 0;
            end
            if (summary)
                $display("%0d tests run, %0d failed, %0d errors", n_tests, n_failed, err_count);
        end
    end

endmodule

// ==== sim/obj_tb.sv ====
// testbench for the object line table, frame memory model and renderer-side reads
`timescale 1ns/1ps

module obj_tb;
    localparam int line_slots = 32;
    localparam int frame_objs = 16;
    localparam int n_reads    = line_slots * 3;   // words 0..2 of each slot

    logic        clk, rst, start, flip, done;
    logic [8:0]  vrender;
    logic [15:0] bank_offset, bank_mask, frame_data, line_data;
    logic [5:0]  frame_addr;
    logic [6:0]  line_addr;

    logic        sample, exact, test_end, summary, timed_out;
    logic [1:0]  word_idx;
    logic [15:0] exp_data, test_id, exp_used;
    int          err_count;

    logic [15:0] frame_mem [0:63];
    logic [15:0] pat [0:1023];
    logic [15:0] exp_q [$];
    int          pos;

    obj_line_table_top #(.line_slots(line_slots), .frame_objs(frame_objs)) obj_line_table_top_i (
        .clk(clk), .rst(rst), .start(start), .flip(flip), .vrender(vrender),
        .bank_offset(bank_offset), .bank_mask(bank_mask),
        .frame_addr(frame_addr), .frame_data(frame_data),
        .line_addr(line_addr), .line_data(line_data), .done(done)
    );

    obj_checker obj_checker_i (
        .clk(clk), .rst(rst), .line_data(line_data), .sample(sample), .exact(exact),
        .word_idx(word_idx), .exp_data(exp_data), .test_end(test_end), .test_id(test_id),
        .exp_used(exp_used), .summary(summary), .err_count(err_count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) frame_data <= frame_mem[frame_addr];   // one cycle read latency

    task automatic wait_done(input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!done && n < 3000) begin
            @(negedge clk);
            n++;
        end
        if (!done) begin
            $display("timeout: no done pulse after the %s of test %0d", what, test_id);
            timed_out = 1'b1;
        end
    endtask

    task automatic build(input logic [8:0] line, input logic fl, input string what);
        @(posedge clk);
        vrender <= line;
        flip    <= fl;
        start   <= 1'b1;
        @(posedge clk);
        start   <= 1'b0;
        wait_done(what);
    endtask

    task automatic run_test();
        logic [8:0] vr;
        logic       fl;
        int         n_obj, n_exp, n_used, j;
        test_id     = pat[pos];
        vr          = pat[pos+1][8:0];
        fl          = pat[pos+2][0];
        n_obj       = int'(pat[pos+5]);
        n_exp       = int'(pat[pos+6]);
        n_used      = int'(pat[pos+7]);
        bank_offset <= pat[pos+3];
        bank_mask   <= pat[pos+4];
        pos += 8;
        // high byte ff everywhere, so the word after the last object ends the list
        for (int i = 0; i < 64; i++)
            frame_mem[i] = 16'hff00 | 16'(i);
        for (int i = 0; i < n_obj * 4; i++)
            frame_mem[i] = pat[pos+i];
        pos += n_obj * 4;
        exp_q.delete();
        for (int i = 0; i < n_exp * 3; i++)
            exp_q.push_back(pat[pos+i]);
        pos += n_exp * 3;

        build(vr, fl, "build");
        if (timed_out)
            return;
        for (int i = 0; i < 4; i++)
            frame_mem[i] = 16'hff00;          // empty list for the other parity
        build(vr ^ 9'd1, fl, "empty build");  // swaps banks for the renderer
        if (timed_out)
            return;

        for (int k = 0; k <= n_reads; k++) begin
            @(posedge clk);
            if (k < n_reads)
                line_addr <= 7'((k / 3) * 4 + k % 3);
            if (k > 0) begin
                j        = k - 1;
                sample   <= 1'b1;
                word_idx <= 2'(j % 3);
                if (j / 3 < n_exp) begin
                    exact    <= 1'b1;
                    exp_data <= exp_q[j];
                end else if (j / 3 >= n_used) begin
                    exact    <= 1'b1;
                    exp_data <= 16'hffff;
                end else begin
                    exact <= 1'b0;   // only counted
                end
            end
        end
        @(posedge clk);
        sample   <= 1'b0;
        exp_used <= 16'(n_used);
        test_end <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
        repeat ($urandom_range(1, 4)) @(posedge clk);   // idle gap
    endtask

    initial begin
        void'($urandom(66848));
        rst         = 1'b1;
        start       = 1'b0;
        flip        = 1'b0;
        vrender     = '0;
        bank_offset = '0;
        bank_mask   = '0;
        frame_data  = '0;
        line_addr   = '0;
        sample      = 1'b0;
        exact       = 1'b0;
        word_idx    = '0;
        exp_data    = '0;
        test_end    = 1'b0;
        test_id     = '0;
        exp_used    = '0;
        summary     = 1'b0;
        timed_out   = 1'b0;
        pos         = 0;
        $readmemh("sim/obj_patterns.txt", pat);
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        while (pat[pos] != 16'h0 && !timed_out)
            run_test();

        @(posedge clk);
        summary <= 1'b1;
        @(posedge clk);
        summary <= 1'b0;
        @(negedge clk);
        if (timed_out || err_count != 0)
            $display("Simulation FAILED");
        else
            $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== sim/obj_patterns.txt ====
// header: id vrender flip bank_offset bank_mask n_objs n_exp n_used
// then n_objs lines of attr code y x, then n_exp lines of info code xpos; id 0 ends
0001 0040 0000 0000 ffff 0001 0001 0001
0005 0123 003c 0080
0405 0123 0080
0002 0042 0000 0000 ffff 0002 0004 0004
0221 0450 0040 0060
2043 0700 002f 0100
0221 0450 0080
0221 0451 0070
0221 0452 0060
0c43 0710 0100
0003 0050 0000 0000 ffff 0005 0002 0002
0001 0200 0050 0090
0001 0200 0050 0090
0001 0300 0060 0090
0001 0400 0050 0020
0002 0500 004f 00a0
0001 0200 0090
0102 0500 00a0
0004 0060 0000 2001 1ff3 0002 0002 0002
0000 2234 0060 0040
0000 c567 005e 0050
0000 3234 0040
0200 2567 0050
0005 0060 0000 5004 f002 0002 0002 0002
0000 2234 0060 0040
0000 c567 005e 0050
0000 6234 0040
0200 d567 0050
0006 0070 0000 0000 ffff 0003 0002 0020
0f00 0100 0070 0040
0f00 0200 0070 0040
0f00 0300 0070 0040
0000 0100 0040
0000 0101 0050
0007 0010 0000 0000 ffff 0003 0002 0002
f000 0a00 0000 0080
0000 0800 0008 0040
0000 0900 00e8 0060
0000 0a10 0080
0800 0800 0040
0008 0010 0001 0000 ffff 0003 0002 0002
f000 0a00 0000 0080
0000 0800 0008 0040
0000 0900 00e8 0060
0f00 0ae0 0080
0700 0900 0060
0000

// ==== all.f ====
common/obj_pkg.sv
logic/obj_zone_match.sv
logic/obj_code_expand.sv
logic/gfx_bank_mapper.sv
obj_table/obj_line_fsm.sv
obj_table/obj_tile_counter.sv
obj_table/obj_line_buf.sv
obj_table/obj_line_table_top.sv
sim/obj_checker.sv
sim/obj_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the object line table testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module obj_tb -f all.f -o obj_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/obj_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
    echo "no result line in sim.log"
    exit 1
fi
exit 0
